//--- bench/bp_checker.sv
// sampled on the rising clock edge; hit_rd is an internal bp_top net reached through the bind
`timescale 1ns/1ps

module bp_checker (
    input logic          clk,
    input logic          rst_n,
    input bp_pkg::word_t pc,          // fetch pc
    input logic          branch,
    input logic          jump,
    input logic          hit_rd,      // fetch lookup hit
    input logic          branch_en,
    input bp_pkg::word_t pc_target,
    input logic          flush
);

    // no redirect while the table is being cleared
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !branch_en)
        else $error("branch_en high while rst_n is low");

    // flush only comes from a resolved branch or jump
    flush_needs_resolve: assert property (@(posedge clk) (!branch && !jump) |-> !flush)
        else $error("flush high with neither branch nor jump");

    // pc mux falls back to the fetch pc on a miss
    miss_returns_pc: assert property (
        @(posedge clk) disable iff (!rst_n) !hit_rd |-> (pc_target == pc)
    ) else $error("pc_target differs from pc on a table miss");

endmodule

bind bp_top bp_checker u_bp_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .branch    (branch),
    .jump      (jump),
    .hit_rd    (hit_rd),
    .branch_en (branch_en),
    .pc_target (pc_target),
    .flush     (flush)
);

//--- bench/bp_patterns.mem
// pc ins pc_ex target_ex ctl exp_pc_target exp_out, one cycle per line
// ctl digits eq jump branch predicted_ex; exp_out digits branch_en flush
00002004 00208463 00000000 00000000 0000 00002004 00
00002008 008000ef 00000000 00000000 0000 00002008 00
0000200c 00100093 00000000 00000000 0000 0000200c 00
00001000 00208463 00001000 00001400 1010 00001000 01
00001000 00208463 00000000 00000000 0000 00001400 10
00002010 00100093 00001024 00001100 0010 00002010 00
00001024 00208463 00000000 00000000 0000 00001100 00
00001000 00208463 00001000 00001400 1011 00001400 10
00001000 00208463 00001000 00001400 1011 00001400 10
00001000 00208463 00001000 00001400 0011 00001400 11
00001000 00208463 00001000 00001400 0011 00001400 11
00001000 00208463 00001000 00001400 0010 00001400 00
00001000 00208463 00001000 00001400 0010 00001400 00
00001000 00208463 00001000 00001400 1010 00001400 01
00001000 00208463 00001000 00001400 1010 00001400 01
00001000 00208463 00000000 00000000 0000 00001400 10
00001000 00100093 00000000 00000000 0000 00001400 00
00002014 008000ef 00003010 00003200 0100 00002014 01
00003010 008000ef 00003010 00003200 0101 00003200 10
00003010 008000ef 00004010 00004300 1010 00003200 11
00003010 008000ef 00000000 00000000 0000 00003010 00
00004010 000080e7 00000000 00000000 0000 00004300 10

//--- bench/bp_tb.sv
// run from the project root; NVEC counts the vector lines, and the last one must be a table hit
`timescale 1ns/1ps
`include "bp_consts.svh"

module bp_tb;

    import bp_pkg::*;

    localparam int NVEC       = 22;                        // vectors in the patterns file
    localparam int WORDS      = 7;                         // hex words per vector
    localparam int RST_CYCLES = 4;
    localparam int MAX_CYCLES = NVEC + 2 * RST_CYCLES + 20;    // timeout limit

    logic  clk;
    logic  rst_n;
    word_t pc;
    word_t ins;
    word_t pc_ex;
    word_t target_ex;
    logic  eq;
    logic  jump;
    logic  branch;
    logic  predicted_ex;
    logic  branch_en;
    word_t pc_target;
    logic  flush;

    logic [31:0] vec_mem [0:NVEC*WORDS-1];   // raw pattern words

    int errors;
    int checks;
    int cycles;    // edges seen, for the timeout

    bp_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .ins          (ins),
        .pc_ex        (pc_ex),
        .target_ex    (target_ex),
        .eq           (eq),
        .jump         (jump),
        .branch       (branch),
        .predicted_ex (predicted_ex),
        .branch_en    (branch_en),
        .pc_target    (pc_target),
        .flush        (flush)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // all inputs low, nothing resolving
    task automatic drive_idle();
        pc           = '0;
        ins          = '0;
        pc_ex        = '0;
        target_ex    = '0;
        eq           = 1'b0;
        jump         = 1'b0;
        branch       = 1'b0;
        predicted_ex = 1'b0;
    endtask

    // one pattern line onto the DUT inputs
    task automatic apply_vector(input int n);
        int          base;
        logic [31:0] ctl;    // one hex digit per flag
        base         = n * WORDS;
        pc           = vec_mem[base];
        ins          = vec_mem[base + 1];
        pc_ex        = vec_mem[base + 2];
        target_ex    = vec_mem[base + 3];
        ctl          = vec_mem[base + 4];
        eq           = ctl[12];
        jump         = ctl[8];
        branch       = ctl[4];
        predicted_ex = ctl[0];
    endtask

    // compare outputs against the expected columns
    task automatic check_vector(input int n);
        int    base;
        word_t exp_tgt;
        logic  exp_be;
        logic  exp_fl;
        base    = n * WORDS;
        exp_tgt = vec_mem[base + 5];
        exp_be  = vec_mem[base + 6][4];   // upper digit
        exp_fl  = vec_mem[base + 6][0];   // lower digit
        checks += 3;
        assert (branch_en === exp_be) else begin
            errors++;
            $display("mismatch branch_en vector %0d: expected %h actual %h",
                     n, exp_be, branch_en);
        end
        assert (pc_target === exp_tgt) else begin
            errors++;
            $display("mismatch pc_target vector %0d: expected %h actual %h",
                     n, exp_tgt, pc_target);
        end
        assert (flush === exp_fl) else begin
            errors++;
            $display("mismatch flush vector %0d: expected %h actual %h",
                     n, exp_fl, flush);
        end
    endtask

    // after a clearing reset edge every lookup misses
    task automatic expect_table_empty(input word_t fetch_pc);
        checks += 2;
        assert (branch_en === 1'b0) else begin
            errors++;
            $display("mismatch branch_en after reset: expected 0 actual %h", branch_en);
        end
        assert (pc_target === fetch_pc) else begin
            errors++;
            $display("mismatch pc_target after reset: expected %h actual %h",
                     fetch_pc, pc_target);
        end
    endtask

    // run limit, counted in clock edges
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        drive_idle();
        $readmemh("bench/bp_patterns.mem", vec_mem);
        repeat (RST_CYCLES) @(posedge clk);   // sync reset clears the valid bits
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < NVEC; n++) begin
            @(posedge clk);
            #1;                 // drive just after the edge
            apply_vector(n);
            #2;                 // sample before the next edge
            check_vector(n);
        end
        @(posedge clk);         // last update lands
        #1;                      // reset again with the table populated
        rst_n = 1'b0;
        drive_idle();            // no control flow in the first reset cycle
        @(posedge clk);          // valid bits cleared here
        #1;
        apply_vector(NVEC - 1);  // a pc that hit before the reset
        repeat (RST_CYCLES - 1) begin
            #2;
            expect_table_empty(pc);
            @(posedge clk);
            #1;
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- btb_predictor.f
+incdir+src
src/bp_pkg.sv
src/tuu_ctrl.sv
src/btb_cache.sv
src/counter_update.sv
src/bp_top.sv
bench/bp_checker.sv
bench/bp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator, run from the project root, then grep the log for the verdict
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f btb_predictor.f --top-module bp_tb \
    -o bp_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/bp_sim > "$LOG" 2>&1 \
    || echo "simulator exited with an error status"

cat "$LOG"

grep -qx "TB PASSED" "$LOG" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see $LOG"; exit 1; }

//--- src/bp_consts.svh
// widths assume RV32 without the C extension, so pc bits 1:0 are always zero
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

`define BP_XLEN     32   // pc and instruction width
`define BP_ENTRIES  16   // direct-mapped table depth
`define BP_IDX_W    4    // index bits, pc[5:2]
`define BP_IDX_LSB  2    // lowest pc bit of the index
`define BP_TAG_W    26   // tag bits, pc[31:6]

// major opcode field, ins[6:0]
`define BP_OP_W      7
`define BP_OP_BRANCH 7'b1100011  // beq/bne/blt/bge/bltu/bgeu
`define BP_OP_JAL    7'b1101111
`define BP_OP_JALR   7'b1100111

`endif

//--- src/bp_pkg.sv
// types only; widths come from the consts header, and the pc split assumes word-aligned pcs
`include "bp_consts.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0]  word_t;  // pc, target or instruction
    typedef logic [`BP_IDX_W-1:0] idx_t;   // table index
    typedef logic [`BP_TAG_W-1:0] tag_t;   // upper pc bits kept per entry

    // 2-bit predictor state
    // bit 1 is the taken prediction
    typedef enum logic [1:0] {
        ctr_weak_nt   = 2'b00,
        ctr_strong_nt = 2'b01,
        ctr_weak_t    = 2'b10,
        ctr_strong_t  = 2'b11
    } ctr_t;

    // table index from the pc
    function automatic idx_t pc_idx(input word_t pc);
        return pc[`BP_IDX_LSB +: `BP_IDX_W];
    endfunction

    // tag is everything above the index
    function automatic tag_t pc_tag(input word_t pc);
        return pc[`BP_XLEN-1 -: `BP_TAG_W];
    endfunction

    // taken prediction of a counter
    function automatic logic ctr_taken(input ctr_t c);
        return c[1];
    endfunction

endpackage

//--- src/bp_top.sv
// no back-pressure; a stalled execute stage must hold branch and jump low
`timescale 1ns/1ps

module bp_top (
    input  logic          clk,
    input  logic          rst_n,         // sync, active low
    // fetch stage
    input  bp_pkg::word_t pc,
    input  bp_pkg::word_t ins,
    // execute stage
    input  bp_pkg::word_t pc_ex,         // resolved pc
    input  bp_pkg::word_t target_ex,     // pc plus immediate
    input  logic          eq,            // outcome taken
    input  logic          jump,
    input  logic          branch,
    input  logic          predicted_ex,
    // predictions
    output logic          branch_en,
    output bp_pkg::word_t pc_target,
    output logic          flush
);

    import bp_pkg::*;

    // fetch lookup
    logic  hit_rd;
    word_t target_rd;
    ctr_t  ctr_rd;
    // execute lookup and update
    logic  hit_wr;
    ctr_t  ctr_wr;
    ctr_t  ctr_next;
    logic  write_en;

    tuu_ctrl u_tuu_ctrl (
        .ins          (ins),
        .hit_rd       (hit_rd),
        .ctr_rd       (ctr_rd),
        .target_rd    (target_rd),
        .pc           (pc),
        .eq           (eq),
        .jump         (jump),
        .branch       (branch),
        .predicted_ex (predicted_ex),
        .branch_en    (branch_en),
        .pc_target    (pc_target),
        .write_en     (write_en),
        .flush        (flush)
    );

    btb_cache u_btb_cache (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_pc     (pc),          // port 1 follows fetch
        .hit_rd    (hit_rd),
        .target_rd (target_rd),
        .ctr_rd    (ctr_rd),
        .wr_pc     (pc_ex),       // port 2 and write follow execute
        .wr_target (target_ex),
        .wr_ctr    (ctr_next),
        .write_en  (write_en),
        .hit_wr    (hit_wr),
        .ctr_wr    (ctr_wr)
    );

    counter_update u_counter_update (
        .hit_wr   (hit_wr),
        .ctr_wr   (ctr_wr),
        .eq       (eq),
        .jump     (jump),
        .ctr_next (ctr_next)
    );

endmodule

//--- src/btb_cache.sv
// direct-mapped, no replacement policy; an alias at the same index evicts the older entry
`timescale 1ns/1ps
`include "bp_consts.svh"

module btb_cache (
    input  logic          clk,
    input  logic          rst_n,       // sync, clears valid bits only
    // read port 1, fetch lookup
    input  bp_pkg::word_t rd_pc,
    output logic          hit_rd,
    output bp_pkg::word_t target_rd,   // don't care on a miss
    output bp_pkg::ctr_t  ctr_rd,      // don't care on a miss
    // read port 2 and write port, execute update
    input  bp_pkg::word_t wr_pc,
    input  bp_pkg::word_t wr_target,
    input  bp_pkg::ctr_t  wr_ctr,
    input  logic          write_en,
    output logic          hit_wr,
    output bp_pkg::ctr_t  ctr_wr       // current counter at wr_pc
);

    import bp_pkg::*;

    // entry storage
    logic [`BP_ENTRIES-1:0] valid_q;              // only this is reset
    tag_t                   tag_q    [`BP_ENTRIES];
    word_t                  target_q [`BP_ENTRIES];
    ctr_t                   ctr_q    [`BP_ENTRIES];

    idx_t rd_idx;   // fetch lookup index
    tag_t rd_tag;
    idx_t wr_idx;   // execute index, shared by port 2 and the write
    tag_t wr_tag;

    // same compare for both read ports
    function automatic logic tag_match(
        input logic v,
        input tag_t stored,
        input tag_t want
    );
        return v && (stored == want);
    endfunction

    // pc split
    assign rd_idx = pc_idx(rd_pc);
    assign rd_tag = pc_tag(rd_pc);
    assign wr_idx = pc_idx(wr_pc);
    assign wr_tag = pc_tag(wr_pc);

    // read port 1
    // reads the array before the edge so a same-cycle update is not seen
    assign hit_rd    = tag_match(valid_q[rd_idx], tag_q[rd_idx], rd_tag);
    assign target_rd = target_q[rd_idx];
    assign ctr_rd    = ctr_q[rd_idx];

    // read port 2, feeds the counter update
    assign hit_wr = tag_match(valid_q[wr_idx], tag_q[wr_idx], wr_tag);
    assign ctr_wr = ctr_q[wr_idx];

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;                 // whole table misses after reset
        end else if (write_en) begin
            valid_q[wr_idx] <= 1'b1;       // allocate or keep
        end
    end

    // payload
    // whole entry rewritten, so a stale target is refreshed too
    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_target;
            ctr_q[wr_idx]    <= wr_ctr;
        end
    end

endmodule

//--- src/counter_update.sv
// combinational next state; the result only matters in a cycle where the table is written
`timescale 1ns/1ps

module counter_update (
    input  logic         hit_wr,    // entry at pc_ex already present
    input  bp_pkg::ctr_t ctr_wr,    // its current counter
    input  logic         eq,        // branch resolved taken
    input  logic         jump,      // jumps count as taken
    output bp_pkg::ctr_t ctr_next   // value written back
);

    import bp_pkg::*;

    logic taken;   // resolved direction

    assign taken = jump || eq;

    always_comb begin
        ctr_next = ctr_wr;   // fallback, every state is listed below
        if (!hit_wr) begin
            // fresh entry starts weak in the resolved direction
            ctr_next = taken ? ctr_weak_t : ctr_weak_nt;
        end else if (taken) begin
            // step toward strong taken
            case (ctr_wr)
                ctr_strong_nt: ctr_next = ctr_weak_nt;
                ctr_weak_nt:   ctr_next = ctr_weak_t;    // flips the prediction
                ctr_weak_t:    ctr_next = ctr_strong_t;
                ctr_strong_t:  ctr_next = ctr_strong_t;  // saturate
                default:       ctr_next = ctr_wr;
            endcase
        end else begin
            // step toward strong not taken
            case (ctr_wr)
                ctr_strong_t:  ctr_next = ctr_weak_t;
                ctr_weak_t:    ctr_next = ctr_weak_nt;   // flips the prediction
                ctr_weak_nt:   ctr_next = ctr_strong_nt;
                ctr_strong_nt: ctr_next = ctr_strong_nt; // saturate
                default:       ctr_next = ctr_wr;
            endcase
        end
    end

endmodule

//--- src/tuu_ctrl.sv
// purely combinational; pc+4, return addresses and history are left to the fetch unit
`timescale 1ns/1ps
`include "bp_consts.svh"

module tuu_ctrl (
    // fetch side
    input  bp_pkg::word_t ins,           // fetched instruction
    input  logic          hit_rd,        // table hit for the fetch pc
    input  bp_pkg::ctr_t  ctr_rd,        // counter of the hit entry
    input  bp_pkg::word_t target_rd,     // stored target of the hit entry
    input  bp_pkg::word_t pc,            // fetch pc
    // execute side
    input  logic          eq,            // resolved outcome is taken
    input  logic          jump,          // resolved jal/jalr
    input  logic          branch,        // resolved b-type
    input  logic          predicted_ex,  // prediction carried down the pipe
    // results
    output logic          branch_en,     // redirect fetch to pc_target
    output bp_pkg::word_t pc_target,     // predicted next pc
    output logic          write_en,      // table update strobe
    output logic          flush          // squash the wrong path
);

    import bp_pkg::*;

    logic [`BP_OP_W-1:0] opcode;     // major opcode of ins
    logic                is_branch;  // b-type
    logic                is_jal;
    logic                is_jalr;
    logic                is_cf;      // any control flow
    logic                pred_taken; // counter says taken
    word_t               hit_target; // target picked by the pc mux

    logic                br_flush;   // conditional branch mispredict
    logic                jmp_flush;  // jump that fetch did not follow

    // opcode decode
    assign opcode = ins[`BP_OP_W-1:0];

    always_comb begin
        is_branch = (opcode == `BP_OP_BRANCH);
        is_jal    = (opcode == `BP_OP_JAL);
        is_jalr   = (opcode == `BP_OP_JALR);
        is_cf     = is_branch || is_jal || is_jalr;
    end

    // counter msb is the direction
    assign pred_taken = ctr_taken(ctr_rd);

    // only control flow may redirect, and only on a hit
    // non-control hits still report the target below
    assign branch_en = is_cf && hit_rd && pred_taken;

    // pc mux
    // stored target on a hit, fetch pc otherwise
    always_comb begin
        hit_target = pc;
        if (hit_rd) begin
            hit_target = target_rd;
        end
    end

    assign pc_target = hit_target;

    // every resolved branch or jump updates its entry
    // a stall must hold branch and jump low or the entry moves twice
    assign write_en = branch || jump;

    // branch went the other way than predicted
    assign br_flush = branch && (eq != predicted_ex);

    // jumps are always taken
    assign jmp_flush = jump && !predicted_ex;

    assign flush = br_flush || jmp_flush;   // same cycle as resolve

endmodule
